//--- logic/lz_job_pkg.sv
// LZ job PE shared types
package lz_job_pkg;

  localparam int JOB_LEN                  = 16;
  localparam int JOB_LEN_LOG2             = 4;
  localparam int ISSUE_WIDTH              = 4;
  localparam int BEATS_PER_JOB            = 4;
  localparam int ADDR_WIDTH               = 16;
  localparam int META_LEN_WIDTH           = 4;
  localparam int MATCH_LEN_WIDTH          = 8;
  localparam int SEQ_LL_BITS              = 8;
  localparam int SEQ_ML_BITS              = 8;
  localparam int SEQ_OFFSET_BITS          = 16;
  localparam int DEFAULT_META_HISTORY_LEN = 8;

  // one hash beat, lane 0 is the lowest position
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]                       head_addr;
    logic [ISSUE_WIDTH-1:0]                      history_valid;
    logic [ISSUE_WIDTH-1:0][ADDR_WIDTH-1:0]      history_addr;
    logic [ISSUE_WIDTH-1:0][META_LEN_WIDTH-1:0]  meta_len;
    logic [ISSUE_WIDTH-1:0]                      can_ext;
    logic                                        delim;
  } hash_beat_t;

  typedef struct packed {
    logic                       valid;
    logic [ADDR_WIDTH-1:0]      history_addr;
    logic [META_LEN_WIDTH-1:0]  meta_len;
    logic                       can_ext;
    logic [SEQ_OFFSET_BITS-1:0] offset;
  } job_entry_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]           head_addr;
    logic                            delim;
    job_entry_t [JOB_LEN-1:0]        entries;
  } job_t;

  typedef struct packed {
    logic                       tail;
    logic [JOB_LEN_LOG2-1:0]    pos;
    logic [JOB_LEN_LOG2-1:0]    seq_head;
    logic [ADDR_WIDTH-1:0]      head_addr;
    logic [ADDR_WIDTH-1:0]      history_addr;
    logic [META_LEN_WIDTH-1:0]  meta_len;
    logic                       can_ext;
    logic [SEQ_OFFSET_BITS-1:0] offset;
    logic                       delim;
  } cand_t;

  typedef struct packed {
    cand_t                      cand;
    logic [MATCH_LEN_WIDTH-1:0] match_len;
  } ext_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] head_addr;
    logic [ADDR_WIDTH-1:0] history_addr;
  } match_req_t;

  typedef struct packed {
    logic [SEQ_LL_BITS-1:0]     ll;
    logic [SEQ_ML_BITS-1:0]     ml;
    logic [SEQ_OFFSET_BITS-1:0] offset;
    logic                       eoj;
    logic                       delim;
  } seq_t;

  typedef struct packed {
    logic [JOB_LEN_LOG2-1:0] next_ptr;
    logic                    job_done;
  } resume_t;

endpackage

//--- logic/job_loader.sv
// hash beat to job loader
module job_loader (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   hash_valid,
  input  lz_job_pkg::hash_beat_t hash_beat,
  output logic                   hash_ready,
  output logic                   job_valid,
  output lz_job_pkg::job_t       job,
  input  logic                   job_ready
);

  localparam int ISSUE_WIDTH     = lz_job_pkg::ISSUE_WIDTH;
  localparam int BEATS_PER_JOB   = lz_job_pkg::BEATS_PER_JOB;
  localparam int BEAT_BITS       = $clog2(BEATS_PER_JOB);
  localparam int ADDR_WIDTH      = lz_job_pkg::ADDR_WIDTH;
  localparam int SEQ_OFFSET_BITS = lz_job_pkg::SEQ_OFFSET_BITS;

  logic [BEAT_BITS-1:0]                         beat_cnt;
  logic                                         job_full;
  logic                                         beat_fire;
  logic                                         last_beat;
  logic [ISSUE_WIDTH-1:0][SEQ_OFFSET_BITS-1:0]  lane_offset;

  // a waiting job may leave on the same edge a new beat arrives
  assign hash_ready = !job_full || job_ready;
  assign job_valid  = job_full;
  assign beat_fire  = hash_valid && hash_ready;
  assign last_beat  = (beat_cnt == BEAT_BITS'(BEATS_PER_JOB - 1));

  // offset from the lane's own address back to its history
  always_comb begin
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      if (hash_beat.history_valid[i]) begin
        lane_offset[i] = SEQ_OFFSET_BITS'(hash_beat.head_addr + ADDR_WIDTH'(i)
                                          - hash_beat.history_addr[i]);
      end else begin
        lane_offset[i] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      job_full <= 1'b0;
    end else begin
      if (beat_fire) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      if (beat_fire && last_beat) begin
        job_full <= 1'b1;
      end else if (job_valid && job_ready) begin
        job_full <= 1'b0;
      end
    end
  end

  // job buffer
  always_ff @(posedge clk) begin
    if (beat_fire) begin
      if (beat_cnt == '0) begin
        job.head_addr <= hash_beat.head_addr;
      end
      if (last_beat) begin
        job.delim <= hash_beat.delim;
      end
      for (int i = 0; i < ISSUE_WIDTH; i++) begin
        job.entries[int'(beat_cnt) * ISSUE_WIDTH + i].valid        <= hash_beat.history_valid[i];
        job.entries[int'(beat_cnt) * ISSUE_WIDTH + i].history_addr <= hash_beat.history_addr[i];
        job.entries[int'(beat_cnt) * ISSUE_WIDTH + i].meta_len     <= hash_beat.meta_len[i];
        job.entries[int'(beat_cnt) * ISSUE_WIDTH + i].can_ext      <= hash_beat.can_ext[i];
        job.entries[int'(beat_cnt) * ISSUE_WIDTH + i].offset       <= lane_offset[i];
      end
    end
  end

endmodule

//--- logic/match_seeker.sv
// match head seeker
module match_seeker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                job_valid,
  input  lz_job_pkg::job_t    job,
  output logic                job_ready,
  output logic                cand_valid,
  output lz_job_pkg::cand_t   cand,
  input  logic                cand_ready,
  input  logic                resume_valid,
  input  lz_job_pkg::resume_t resume
);

  localparam int JOB_LEN  = lz_job_pkg::JOB_LEN;
  localparam int PTR_BITS = lz_job_pkg::JOB_LEN_LOG2;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEEK,
    S_CAND,
    S_WAIT
  } state_t;

  state_t                 state;
  lz_job_pkg::job_t       job_q;
  logic [PTR_BITS-1:0]    seq_head;
  logic [PTR_BITS-1:0]    match_head;
  logic [JOB_LEN-1:0]     valid_vec;
  logic [JOB_LEN-1:0]     valid_ahead;
  lz_job_pkg::job_entry_t head_entry;
  logic                   hit;
  logic                   at_end;
  logic                   skip8;
  logic                   skip4;

  always_comb begin
    for (int i = 0; i < JOB_LEN; i++) begin
      valid_vec[i] = job_q.entries[i].valid;
    end
  end

  // bit 0 lines up with the match head
  assign valid_ahead = valid_vec >> match_head;
  assign head_entry  = job_q.entries[match_head];
  assign hit         = head_entry.valid;
  assign at_end      = (match_head == PTR_BITS'(JOB_LEN - 1));
  assign skip8       = (int'(match_head) < JOB_LEN - 8) && (valid_ahead[7:0] == '0);
  assign skip4       = (int'(match_head) < JOB_LEN - 4) && (valid_ahead[3:0] == '0);

  assign job_ready  = (state == S_IDLE);
  assign cand_valid = (state == S_CAND);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      seq_head   <= '0;
      match_head <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (job_valid) begin
            state      <= S_SEEK;
            seq_head   <= '0;
            match_head <= '0;
          end
        end
        S_SEEK: begin
          if (hit || at_end) begin
            state <= S_CAND;
          end else if (skip8) begin
            match_head <= match_head + PTR_BITS'(8);
          end else if (skip4) begin
            match_head <= match_head + PTR_BITS'(4);
          end else begin
            match_head <= match_head + PTR_BITS'(1);
          end
        end
        S_CAND: begin
          // a tail too gets its resume, with job_done set
          if (cand_ready) begin
            state <= S_WAIT;
          end
        end
        default: begin
          if (resume_valid) begin
            if (resume.job_done) begin
              state <= S_IDLE;
            end else begin
              state      <= S_SEEK;
              seq_head   <= resume.next_ptr;
              match_head <= resume.next_ptr;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (job_valid && job_ready) begin
      job_q <= job;
    end
    if (state == S_SEEK && (hit || at_end)) begin
      cand.tail         <= !hit;
      cand.pos          <= match_head;
      cand.seq_head     <= seq_head;
      cand.head_addr    <= job_q.head_addr;
      cand.history_addr <= head_entry.history_addr;
      cand.meta_len     <= head_entry.meta_len;
      cand.can_ext      <= head_entry.can_ext;
      cand.offset       <= head_entry.offset;
      cand.delim        <= job_q.delim;
    end
  end

endmodule

//--- logic/match_extender.sv
// match length extender
module match_extender #(
  parameter int META_HISTORY_LEN = lz_job_pkg::DEFAULT_META_HISTORY_LEN
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    cand_valid,
  input  lz_job_pkg::cand_t                       cand,
  output logic                                    cand_ready,
  output logic                                    match_req_valid,
  output lz_job_pkg::match_req_t                  match_req,
  input  logic                                    match_req_ready,
  input  logic                                    match_resp_valid,
  input  logic [lz_job_pkg::MATCH_LEN_WIDTH-1:0]  match_resp_len,
  output logic                                    match_resp_ready,
  output logic                                    ext_valid,
  output lz_job_pkg::ext_t                        ext,
  input  logic                                    ext_ready
);

  localparam int ADDR_WIDTH      = lz_job_pkg::ADDR_WIDTH;
  localparam int MATCH_LEN_WIDTH = lz_job_pkg::MATCH_LEN_WIDTH;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_RESP,
    S_OUT
  } state_t;

  state_t state;

  assign cand_ready       = (state == S_IDLE);
  assign match_req_valid  = (state == S_REQ);
  assign match_resp_ready = (state == S_RESP);
  assign ext_valid        = (state == S_OUT);

  // the meta history part is already known to match, start past it
  assign match_req.head_addr    = ext.cand.head_addr + ADDR_WIDTH'(ext.cand.pos)
                                  + ADDR_WIDTH'(META_HISTORY_LEN);
  assign match_req.history_addr = ext.cand.history_addr + ADDR_WIDTH'(META_HISTORY_LEN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (cand_valid) begin
            state <= (cand.tail || !cand.can_ext) ? S_OUT : S_REQ;
          end
        end
        S_REQ: begin
          if (match_req_ready) begin
            state <= S_RESP;
          end
        end
        S_RESP: begin
          if (match_resp_valid) begin
            state <= S_OUT;
          end
        end
        default: begin
          if (ext_ready) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cand_valid && cand_ready) begin
      ext.cand      <= cand;
      ext.match_len <= MATCH_LEN_WIDTH'(cand.meta_len);
    end else if (match_resp_valid && match_resp_ready) begin
      ext.match_len <= ext.match_len + match_resp_len;
    end
  end

endmodule

//--- logic/seq_emitter.sv
// output sequence emitter
module seq_emitter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ext_valid,
  input  lz_job_pkg::ext_t    ext,
  output logic                ext_ready,
  output logic                seq_valid,
  output lz_job_pkg::seq_t    seq,
  input  logic                seq_ready,
  output logic                resume_valid,
  output lz_job_pkg::resume_t resume
);

  localparam int JOB_LEN     = lz_job_pkg::JOB_LEN;
  localparam int PTR_BITS    = lz_job_pkg::JOB_LEN_LOG2;
  localparam int LL_BITS     = lz_job_pkg::SEQ_LL_BITS;
  localparam int ML_BITS     = lz_job_pkg::SEQ_ML_BITS;
  localparam int END_BITS    = lz_job_pkg::MATCH_LEN_WIDTH + 1;

  logic [END_BITS-1:0] end_pos;
  logic                reach_end;

  // position just past the match, may run beyond the job
  assign end_pos   = END_BITS'(ext.cand.pos) + END_BITS'(ext.match_len);
  assign reach_end = (end_pos >= END_BITS'(JOB_LEN));

  assign ext_ready    = !seq_valid;
  assign resume_valid = seq_valid && seq_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seq_valid <= 1'b0;
    end else if (ext_valid && ext_ready) begin
      seq_valid <= 1'b1;
    end else if (seq_ready) begin
      seq_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_valid && ext_ready) begin
      seq.delim <= ext.cand.delim;
      if (ext.cand.tail) begin
        seq.ll          <= LL_BITS'(JOB_LEN) - LL_BITS'(ext.cand.seq_head);
        seq.ml          <= '0;
        seq.offset      <= '0;
        seq.eoj         <= 1'b1;
        resume.next_ptr <= ext.cand.pos;
        resume.job_done <= 1'b1;
      end else begin
        seq.ll          <= LL_BITS'(ext.cand.pos - ext.cand.seq_head);
        seq.ml          <= ML_BITS'(ext.match_len);
        seq.offset      <= ext.cand.offset;
        seq.eoj         <= reach_end;
        resume.next_ptr <= PTR_BITS'(end_pos);
        resume.job_done <= reach_end;
      end
    end
  end

endmodule

//--- logic/lz_job_pe.sv
// LZ job processing element
module lz_job_pe #(
  parameter int META_HISTORY_LEN = lz_job_pkg::DEFAULT_META_HISTORY_LEN
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    hash_valid,
  input  lz_job_pkg::hash_beat_t                  hash_beat,
  output logic                                    hash_ready,
  output logic                                    match_req_valid,
  output lz_job_pkg::match_req_t                  match_req,
  input  logic                                    match_req_ready,
  input  logic                                    match_resp_valid,
  input  logic [lz_job_pkg::MATCH_LEN_WIDTH-1:0]  match_resp_len,
  output logic                                    match_resp_ready,
  output logic                                    seq_valid,
  output lz_job_pkg::seq_t                        seq,
  input  logic                                    seq_ready
);

  logic                job_valid;
  lz_job_pkg::job_t    job;
  logic                job_ready;
  logic                cand_valid;
  lz_job_pkg::cand_t   cand;
  logic                cand_ready;
  logic                ext_valid;
  lz_job_pkg::ext_t    ext;
  logic                ext_ready;
  logic                resume_valid;
  lz_job_pkg::resume_t resume;

  job_loader u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .hash_valid (hash_valid),
    .hash_beat  (hash_beat),
    .hash_ready (hash_ready),
    .job_valid  (job_valid),
    .job        (job),
    .job_ready  (job_ready)
  );

  match_seeker u_seeker (
    .clk          (clk),
    .rst_n        (rst_n),
    .job_valid    (job_valid),
    .job          (job),
    .job_ready    (job_ready),
    .cand_valid   (cand_valid),
    .cand         (cand),
    .cand_ready   (cand_ready),
    .resume_valid (resume_valid),
    .resume       (resume)
  );

  match_extender #(
    .META_HISTORY_LEN (META_HISTORY_LEN)
  ) u_extender (
    .clk              (clk),
    .rst_n            (rst_n),
    .cand_valid       (cand_valid),
    .cand             (cand),
    .cand_ready       (cand_ready),
    .match_req_valid  (match_req_valid),
    .match_req        (match_req),
    .match_req_ready  (match_req_ready),
    .match_resp_valid (match_resp_valid),
    .match_resp_len   (match_resp_len),
    .match_resp_ready (match_resp_ready),
    .ext_valid        (ext_valid),
    .ext              (ext),
    .ext_ready        (ext_ready)
  );

  seq_emitter u_emitter (
    .clk          (clk),
    .rst_n        (rst_n),
    .ext_valid    (ext_valid),
    .ext          (ext),
    .ext_ready    (ext_ready),
    .seq_valid    (seq_valid),
    .seq          (seq),
    .seq_ready    (seq_ready),
    .resume_valid (resume_valid),
    .resume       (resume)
  );

endmodule

//--- verif/job_vectors.svh
// LZ job PE test vectors
`ifndef JOB_VECTORS_SVH
`define JOB_VECTORS_SVH

localparam int NUM_JOBS = 4;
localparam int NUM_SEQS = 8;
localparam int NUM_REQS = 3;

// tail jobs are followed by jobs with matches
string       job_name  [NUM_JOBS] = '{"exact_end", "empty_job", "resume_tail", "wrap_skip"};
logic [15:0] job_head  [NUM_JOBS] = '{16'h0200, 16'h0100, 16'h1000, 16'hfff8};
logic        job_delim [NUM_JOBS] = '{1'b1, 1'b0, 1'b1, 1'b0};

// columns: valid, can_ext, meta length (one hex digit each), history address
// four positions per row, four rows per job
logic [27:0] job_entry [NUM_JOBS*16] = '{
  28'h0,        28'h0,        28'h0,        28'h10501f0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h1110105,  28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h1140f00,  28'h0,        28'h0,        28'h0,
  28'h0,        28'h1020ff3,  28'h1190aaa,  28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h103ffe0,  28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h0,        28'h0,
  28'h0,        28'h0,        28'h0,        28'h111ff07
};

// columns: ll, ml, offset, eoj, delim
logic [33:0] exp_seq [NUM_SEQS] = '{
  {8'd3,  8'd5, 16'h0013, 1'b0, 1'b1},
  {8'd2,  8'd6, 16'h0105, 1'b1, 1'b1},
  {8'd16, 8'd0, 16'h0000, 1'b1, 1'b0},
  {8'd0,  8'd4, 16'h0100, 1'b0, 1'b1},
  {8'd1,  8'd2, 16'h0012, 1'b0, 1'b1},
  {8'd9,  8'd0, 16'h0000, 1'b1, 1'b1},
  {8'd2,  8'd3, 16'h001a, 1'b0, 1'b0},
  {8'd10, 8'd8, 16'h0100, 1'b1, 1'b0}
};
int exp_seq_job [NUM_SEQS] = '{0, 0, 1, 2, 2, 2, 3, 3};

// columns: head address, history address
logic [31:0] exp_req [NUM_REQS] = '{
  {16'h0212, 16'h010d},
  {16'h1008, 16'h0f08},
  {16'h000f, 16'hff0f}
};
int exp_req_job [NUM_REQS] = '{0, 2, 3};

`endif

//--- verif/tb_lz_job_pe.sv
// LZ job PE testbench
module tb_lz_job_pe;

  `include "job_vectors.svh"

  localparam int TIMEOUT_CYCLES = 200 * NUM_JOBS;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   hash_valid;
  lz_job_pkg::hash_beat_t                 hash_beat;
  logic                                   hash_ready;
  logic                                   match_req_valid;
  lz_job_pkg::match_req_t                 match_req;
  logic                                   match_req_ready;
  logic                                   match_resp_valid;
  logic [lz_job_pkg::MATCH_LEN_WIDTH-1:0] match_resp_len;
  logic                                   match_resp_ready;
  logic                                   seq_valid;
  lz_job_pkg::seq_t                       seq;
  logic                                   seq_ready;

  logic [31:0] lfsr = 32'h6de4;
  int          errors = 0;
  int          seq_count = 0;
  int          req_count = 0;
  int          cycles = 0;
  logic        resp_pending = 1'b0;
  logic        resp_fire = 1'b0;
  logic [7:0]  pending_len = '0;

  lz_job_pe #(
    .META_HISTORY_LEN (lz_job_pkg::DEFAULT_META_HISTORY_LEN)
  ) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .hash_valid       (hash_valid),
    .hash_beat        (hash_beat),
    .hash_ready       (hash_ready),
    .match_req_valid  (match_req_valid),
    .match_req        (match_req),
    .match_req_ready  (match_req_ready),
    .match_resp_valid (match_resp_valid),
    .match_resp_len   (match_resp_len),
    .match_resp_ready (match_resp_ready),
    .seq_valid        (seq_valid),
    .seq              (seq),
    .seq_ready        (seq_ready)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // beat k covers positions 4k..4k+3, its head address is the first of them
  function automatic lz_job_pkg::hash_beat_t make_beat(input int job_idx, input int beat_idx);
    lz_job_pkg::hash_beat_t b;
    logic [27:0]            e;
    b           = '0;
    b.head_addr = job_head[job_idx] + 16'(4 * beat_idx);
    b.delim     = job_delim[job_idx];
    for (int i = 0; i < lz_job_pkg::ISSUE_WIDTH; i++) begin
      e                  = job_entry[job_idx * 16 + beat_idx * 4 + i];
      b.history_valid[i] = e[24];
      b.can_ext[i]       = e[20];
      b.meta_len[i]      = e[19:16];
      b.history_addr[i]  = e[15:0];
    end
    return b;
  endfunction

  task automatic wait_beat_accepted();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = hash_ready;
      @(posedge clk);
      #1;
    end
  endtask

  // handshake outputs right after reset
  task automatic check_reset_state();
    if (hash_ready !== 1'b1) begin
      errors++;
      $display("Error reset hash_ready exp 1 act %b", hash_ready);
    end
    if ({seq_valid, match_req_valid, match_resp_ready} !== 3'b000) begin
      errors++;
      $display("Error reset seq_valid match_req_valid match_resp_ready exp 000 act %b%b%b",
               seq_valid, match_req_valid, match_resp_ready);
    end
  endtask

  task automatic check_sequence();
    lz_job_pkg::seq_t exp;
    if (seq_count >= NUM_SEQS) begin
      errors++;
      $display("unexpected sequence beyond the %0d expected ones", NUM_SEQS);
    end else begin
      exp = exp_seq[seq_count];
      if (seq !== exp) begin
        errors++;
        $display("Error %s seq %0d (ll ml off eoj delim) exp %0d %0d %h %b %b act %0d %0d %h %b %b",
                 job_name[exp_seq_job[seq_count]], seq_count,
                 exp.ll, exp.ml, exp.offset, exp.eoj, exp.delim,
                 seq.ll, seq.ml, seq.offset, seq.eoj, seq.delim);
      end
    end
    seq_count++;
  endtask

  // the response length is the request's history address mod 8
  task automatic check_request();
    logic [31:0] exp;
    if (req_count >= NUM_REQS) begin
      errors++;
      $display("unexpected match request beyond the %0d expected ones", NUM_REQS);
    end else begin
      exp = exp_req[req_count];
      if (match_req !== exp) begin
        errors++;
        $display("Error %s req %0d (head hist) exp %h %h act %h %h",
                 job_name[exp_req_job[req_count]], req_count, exp[31:16], exp[15:0],
                 match_req.head_addr, match_req.history_addr);
      end
    end
    req_count++;
    pending_len  = 8'(match_req.history_addr % 16'd8);
    resp_pending = 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, errors %0d, %0d of %0d sequences seen",
               cycles, errors, seq_count, NUM_SEQS);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // transfers are decided at the next rising edge, inputs are settled here
  always @(negedge clk) begin
    if (rst_n) begin
      if (match_req_valid && match_req_ready) begin
        check_request();
      end
      if (match_resp_valid && match_resp_ready) begin
        resp_fire = 1'b1;
      end
      if (seq_valid && seq_ready) begin
        check_sequence();
      end
    end
  end

  // seq_ready and the match request/response timing
  initial begin : handshake_driver
    int req_wait;
    int resp_wait;
    int bit_val;
    random_bits(2, req_wait);
    random_bits(2, resp_wait);
    forever begin
      @(posedge clk);
      #1;
      random_bits(1, bit_val);
      seq_ready = (bit_val != 0);
      if (match_req_ready && !match_req_valid) begin
        match_req_ready = 1'b0;
      end else if (match_req_valid && !match_req_ready) begin
        if (req_wait == 0) begin
          match_req_ready = 1'b1;
          random_bits(2, req_wait);
        end else begin
          req_wait = req_wait - 1;
        end
      end
      if (resp_fire) begin
        match_resp_valid = 1'b0;
        resp_fire        = 1'b0;
      end else if (resp_pending && !match_resp_valid) begin
        if (resp_wait == 0) begin
          match_resp_valid = 1'b1;
          match_resp_len   = pending_len;
          resp_pending     = 1'b0;
          random_bits(2, resp_wait);
        end else begin
          resp_wait = resp_wait - 1;
        end
      end
    end
  end

  initial begin
    rst_n            = 1'b0;
    hash_valid       = 1'b0;
    hash_beat        = '0;
    match_req_ready  = 1'b0;
    match_resp_valid = 1'b0;
    match_resp_len   = '0;
    seq_ready        = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    check_reset_state();
    rst_n = 1'b1;

    // all jobs back to back
    for (int j = 0; j < NUM_JOBS; j++) begin
      for (int b = 0; b < lz_job_pkg::BEATS_PER_JOB; b++) begin
        hash_valid = 1'b1;
        hash_beat  = make_beat(j, b);
        wait_beat_accepted();
      end
    end
    hash_valid = 1'b0;
    hash_beat  = '0;

    while (seq_count < NUM_SEQS) @(posedge clk);
    // quiet period to catch extra output
    repeat (20) @(posedge clk);
    if (req_count != NUM_REQS) begin
      errors++;
      $display("wrong number of match requests, expected %0d but saw %0d", NUM_REQS, req_count);
    end
    $display("errors %0d, sequences %0d of %0d, requests %0d of %0d",
             errors, seq_count, NUM_SEQS, req_count, NUM_REQS);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+verif
logic/lz_job_pkg.sv
logic/job_loader.sv
logic/match_seeker.sv
logic/match_extender.sv
logic/seq_emitter.sv
logic/lz_job_pe.sv
verif/tb_lz_job_pe.sv

//--- Bender.yml
package:
  name: lz_job_pe

sources:
  - logic/lz_job_pkg.sv
  - logic/job_loader.sv
  - logic/match_seeker.sv
  - logic/match_extender.sv
  - logic/seq_emitter.sv
  - logic/lz_job_pe.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_lz_job_pe.sv
